/* Makefile */
TOP = icache_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sim.f hw/*.sv hw/*.svh bench/*.sv
	verilator --binary --assert -f sim.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^Simulation finished: PASS$$" $(LOG)

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

/* bench/icache_assertions.sv */
// Bound checks on the cache bus request: one-cycle pulses, aligned address, only under a core request
`timescale 1ns/1ps

module icache_assertions import fsab_pkg::*; (
	input logic       clk,
	input logic       rst_b,
	input logic       rd_req,
	input logic       fsabo_valid,
	input fsab_addr_t fsabo_addr
);

	// One request per fill, so never back to back
	valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_b)
		fsabo_valid |=> !fsabo_valid)
		else $error("fsabo_valid high for two consecutive cycles");

	// Whole-line reads only
	addr_line_aligned: assert property (@(posedge clk) disable iff (!rst_b)
		fsabo_valid |-> (fsabo_addr[5:0] == 6'b0))
		else $error("fsabo_addr not line aligned: 0x%0h", fsabo_addr);

	// A miss needs a core request behind it
	valid_needs_req: assert property (@(posedge clk) disable iff (!rst_b)
		fsabo_valid |-> rd_req)
		else $error("fsabo_valid high without rd_req");

endmodule

bind icache_top icache_assertions u_assertions (
	.clk         (clk),
	.rst_b       (rst_b),
	.rd_req      (rd_req),
	.fsabo_valid (fsabo_valid),
	.fsabo_addr  (fsabo_addr)
);

/* bench/icache_tb.sv */
// Cache testbench with clocks, resets, random core reads, bus responder, reference model, watchdog
`timescale 1ns/1ps
`include "fsab_params.svh"

module icache_tb import ic_pkg::*; import fsab_pkg::*; ();

	localparam int NUM_READS     = 300;
	localparam int HOLD_READS    = 6;    // Enough misses to drain every credit
	localparam int WORST_FILL_NS = 400;  // Credit wait, bus delay, stray beats, sync back
	localparam int WATCHDOG_NS   = (NUM_READS + NUM_READS / 2 + 3 + HOLD_READS) * WORST_FILL_NS;
	localparam int INIT_CREDITS  = int'(`FSAB_INITIAL_CREDITS);

	logic       clk;
	logic       rst_b;
	logic       rd_req;
	logic       rd_wait;
	logic       fsabo_valid;
	logic       fsabo_credit;
	logic       fsabi_clk;
	logic       fsabi_rst_b;
	logic       fsabi_valid;
	ic_addr_t   rd_addr;
	ic_word_t   rd_data;
	fsab_addr_t fsabo_addr;
	fsab_did_t  fsabi_did;
	fsab_did_t  fsabi_subdid;
	fsab_data_t fsabi_data;

	int          seed = 51;
	logic [15:0] model_valid = '0;      // Tag model of the cache
	ic_tag_t     model_tag [16];
	fsab_addr_t  req_q [$];             // Requests waiting for the responder
	fsab_addr_t  last_req_addr;
	int          req_count = 0;
	int          read_base = 0;         // req_count when the current read began
	int          in_flight = 0;         // Requests not yet credited
	int          stall_cycles = 0;
	int          hits = 0;
	int          misses = 0;
	logic        hold_credits = 1'b0;
	logic        starved_seen = 1'b0;
	logic        valid_prev = 1'b0;

	icache_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		fsabi_clk = 1'b0;
		forever #3 fsabi_clk = ~fsabi_clk;
	end

	task automatic expect_equal(input string name, input logic [63:0] actual,
	                            input logic [63:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED: %s actual 0x%0h expected 0x%0h at %0t",
			         name, actual, expected, $time);
			$display("Simulation finished: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic int rand_range(input int lo, input int hi);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return lo + (r % (hi - lo + 1));
	endfunction

	// Each word holds its own word address inverted
	function automatic ic_word_t mem_word(input logic [31:0] byte_addr);
		return ~{2'b00, byte_addr[31:2]};
	endfunction

	function automatic fsab_data_t mem_beat(input logic [31:0] line, input int pos);
		logic [31:0] base;
		base = line + 32'(pos) * 32'd8;
		return {mem_word(base + 32'd4), mem_word(base)}; // High word at the higher address
	endfunction

	// Three tags alias onto indices 0 to 7
	function automatic ic_addr_t pick_addr();
		ic_addr_t a;
		a = 32'h0010_0000;
		a[11:10] = 2'(rand_range(0, 2));
		a[8:6]   = 3'(rand_range(0, 7));
		a[5:2]   = 4'(rand_range(0, 15));
		return a;
	endfunction

	// Called and returns at 1 ns after a rising clk
	task automatic core_read(input ic_addr_t addr);
		ic_index_t idx;
		logic      expect_hit;
		int        count_before;
		idx = addr[9:6];
		expect_hit = model_valid[idx] && (model_tag[idx] == addr[31:10]);
		count_before = req_count;
		read_base = count_before;
		rd_req = 1'b1;
		rd_addr = addr;
		@(negedge clk);
		expect_equal("rd_wait", 64'(rd_wait), 64'(!expect_hit));
		while (rd_wait) @(negedge clk);            // Held until the fill lands
		expect_equal("fsabo_valid pulses", 64'(req_count - count_before), 64'(!expect_hit));
		if (expect_hit) begin
			hits++;
		end else begin
			expect_equal("fsabo_addr", 64'(last_req_addr), 64'({addr[31:6], 6'b0}));
			model_valid[idx] = 1'b1;
			model_tag[idx] = addr[31:10];
			misses++;
		end
		@(posedge clk);
		#1;
		expect_equal("rd_data", 64'(rd_data), 64'(mem_word(addr)));
	endtask

	// One beat per bus cycle with stray ids mixed in
	task automatic send_line(input fsab_addr_t line);
		int pos;
		pos = 0;
		while (pos < `FSAB_LINE_BEATS) begin
			@(posedge fsabi_clk);
			#1;
			fsabi_valid = 1'b1;
			fsabi_did = `FSAB_DID_CPU;
			fsabi_subdid = `FSAB_SUBDID_ICACHE;
			if (rand_range(0, 3) == 0) begin
				fsabi_data = {$random(seed), $random(seed)};  // Junk for another device
				if (rand_range(0, 1) == 0) fsabi_did = `FSAB_DID_CPU ^ 4'(rand_range(1, 15));
				else fsabi_subdid = `FSAB_SUBDID_ICACHE ^ 4'(rand_range(1, 15));
			end else begin
				fsabi_data = mem_beat(line, pos);
				pos++;
			end
		end
		@(posedge fsabi_clk);
		#1;
		fsabi_valid = 1'b0;
	endtask

	initial begin : bus_responder
		fsab_addr_t line;
		fsabi_rst_b = 1'b0;
		fsabi_valid = 1'b0;
		fsabi_did = '0;
		fsabi_subdid = '0;
		fsabi_data = '0;
		repeat (2) @(posedge fsabi_clk);
		#1;
		fsabi_rst_b = 1'b1;
		forever begin
			@(posedge fsabi_clk);
			if (req_q.size() != 0) begin
				line = req_q.pop_front();
				repeat (rand_range(3, 9)) @(posedge fsabi_clk); // 4 to 10 cycles in all
				send_line(line);
			end
		end
	end

	initial begin : credit_return
		fsabo_credit = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			fsabo_credit = 1'b0;
			if (in_flight > 0 && !hold_credits && rand_range(0, 5) == 0) begin
				fsabo_credit = 1'b1;
				in_flight--;
			end
		end
	end

	// Mid-cycle look at the request port
	always @(negedge clk) begin : request_monitor
		if (rst_b && fsabo_valid) begin
			expect_equal("fsabo_valid repeat", 64'(valid_prev), 64'(0));
			expect_equal("fsabo_addr low bits", 64'(fsabo_addr[5:0]), 64'(0));
			expect_equal("rd_req at request", 64'(rd_req), 64'(1));
			req_q.push_back(fsabo_addr);
			last_req_addr = fsabo_addr;
			req_count++;
			in_flight++;
			expect_equal("requests over credit", 64'(in_flight > INIT_CREDITS), 64'(0));
		end
		valid_prev = rst_b && fsabo_valid;
		// Miss still waiting for its request while every credit is out
		if (hold_credits && in_flight == INIT_CREDITS && rd_wait && req_count == read_base) begin
			stall_cycles++;
			if (stall_cycles >= 20) begin           // Starved long enough so credits flow again
				hold_credits = 1'b0;
				starved_seen = 1'b1;
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired: the reads did not complete in the expected time");
		$display("Simulation finished: FAIL");
		$fatal(1, "timeout");
	end

	initial begin : core_side
		int i;
		rst_b = 1'b0;
		rd_req = 1'b0;
		rd_addr = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_b = 1'b1;
		for (i = 0; i < NUM_READS + NUM_READS / 2 + 3 + HOLD_READS; i++) begin
			if (rand_range(0, 3) == 0) begin
				rd_req = 1'b0;                      // Idle gap
				repeat (rand_range(1, 3)) @(posedge clk);
				#1;
			end
			if (i == NUM_READS) begin
				core_read(32'h0010_0240);           // Index 9 outside the pool
				core_read(32'h0020_0244);           // Same index with another tag
				core_read(32'h0010_0248);           // Evicted line misses again
				hold_credits = 1'b1;
			end
			if (i >= NUM_READS && i < NUM_READS + HOLD_READS) begin
				core_read(32'h0040_0000 + 32'(i - NUM_READS) * 32'h40);
			end else if (i < NUM_READS || i >= NUM_READS + HOLD_READS + 3) begin
				core_read(pick_addr());
			end
		end
		expect_equal("credit stall seen", 64'(starved_seen), 64'(1));
		expect_equal("hits seen", 64'(hits > 0), 64'(1));
		expect_equal("misses seen", 64'(misses > 0), 64'(1));
		$display("Reads done: %0d hits, %0d misses", hits, misses);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* hw/fsab_params.svh */
// System bus constants: device ids, credits at reset, beats per cache line
`ifndef FSAB_PARAMS_SVH
`define FSAB_PARAMS_SVH

// Responses are routed by device and subdevice id
`define FSAB_DID_CPU         4'h0
`define FSAB_SUBDID_ICACHE   4'h1

// Credits granted to the requester out of reset
`define FSAB_INITIAL_CREDITS 3'd4

// 64-byte line, 8 bytes per beat
`define FSAB_LINE_BEATS      8

`endif

/* hw/fsab_pkg.sv */
// System bus types: address, data beat, device id, credit counter
package fsab_pkg;

	typedef logic [31:0] fsab_addr_t;   // Request address, line aligned for reads
	typedef logic [63:0] fsab_data_t;   // One response beat
	typedef logic [3:0]  fsab_did_t;    // Device or subdevice id
	typedef logic [2:0]  fsab_credit_t; // Outstanding request credits

	// Beats carry two words; high word sits at the higher byte address
	localparam int FSAB_WORD_W = 32;

endpackage

/* hw/ic_data_ram.sv */
// Cache data array: beat writes on the bus clock, registered word reads on the core clock
`timescale 1ns/1ps

module ic_data_ram import ic_pkg::*; import fsab_pkg::*; (
	input  logic       clk,
	input  ic_addr_t   rd_addr,    // Core lookup address
	output ic_word_t   rd_data,    // Word, one cycle after the address
	input  logic       fsabi_clk,
	input  logic       beat_we,    // Write one beat
	input  logic [6:0] beat_index, // {line, beat}
	input  fsab_data_t beat_data
);

	// 128 beats split into two word-wide halves
	ic_word_t data_hi [128];
	ic_word_t data_lo [128];

	logic [6:0] rd_index;
	ic_word_t   rd_hi;
	ic_word_t   rd_lo;

	// Line and beat of the core address
	assign rd_index = {rd_addr[IC_INDEX_LSB +: 4], rd_addr[IC_BEAT_LSB +: 3]};
	assign rd_hi    = data_hi[rd_index];
	assign rd_lo    = data_lo[rd_index];

	// Fill side, bus clock domain
	always_ff @(posedge fsabi_clk) begin
		if (beat_we) begin
			data_hi[beat_index] <= beat_data[63:FSAB_WORD_W];
			data_lo[beat_index] <= beat_data[FSAB_WORD_W-1:0];
		end
	end

	// Read every cycle, hit or not; core only looks on a hit
	always_ff @(posedge clk) begin
		rd_data <= rd_addr[IC_HALF_BIT] ? rd_hi : rd_lo; // Bit 2 selects the half
	end

endmodule

/* hw/ic_fill_unit.sv */
// Fill unit: start toggle sync, response id filter, beat counter, completion toggle
`timescale 1ns/1ps
`include "fsab_params.svh"

module ic_fill_unit import ic_pkg::*; import fsab_pkg::*; (
	input  logic       fsabi_clk,
	input  logic       fsabi_rst_b,
	input  logic       cur_read,     // Core domain toggle
	input  ic_addr_t   fill_addr,    // Stable long before data arrives
	input  logic       fsabi_valid,
	input  fsab_did_t  fsabi_did,
	input  fsab_did_t  fsabi_subdid,
	input  fsab_data_t fsabi_data,
	output logic       beat_we,
	output logic [6:0] beat_index,   // {line, beat}
	output fsab_data_t beat_data,
	output logic       done_read     // Toggle back to the core domain
);

	logic      cur_s1;
	logic      cur_sync;
	logic      cur_prev;             // For edge detect
	logic      new_fill;
	logic      beat_ok;
	logic      last_beat;
	ic_beat_t  beat_cnt;
	ic_index_t fill_index;

	assign new_fill   = cur_sync ^ cur_prev;
	assign beat_ok    = fsabi_valid && (fsabi_did == `FSAB_DID_CPU)
	                    && (fsabi_subdid == `FSAB_SUBDID_ICACHE);
	assign last_beat  = (beat_cnt == ic_beat_t'(`FSAB_LINE_BEATS - 1));
	assign fill_index = fill_addr[IC_INDEX_LSB +: 4];

	// Beats arrive in order, so the counter is the position
	assign beat_we    = beat_ok && !new_fill;
	assign beat_index = {fill_index, beat_cnt};
	assign beat_data  = fsabi_data;

	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			cur_s1    <= 1'b0;
			cur_sync  <= 1'b0;
			cur_prev  <= 1'b0;
			beat_cnt  <= '0;
			done_read <= 1'b0;
		end else begin
			cur_s1   <= cur_read;
			cur_sync <= cur_s1;
			cur_prev <= cur_sync;
			if (new_fill) begin
				beat_cnt <= '0;                      // Fresh line
			end else if (beat_ok) begin
				beat_cnt <= beat_cnt + 3'd1;         // Wraps to 0 after the last beat
				if (last_beat) begin
					done_read <= cur_sync;           // Match means done
				end
			end
		end
	end

endmodule

/* hw/ic_miss_ctrl.sv */
// Miss control: bus credits, IDLE/FILLING FSM, line read request, core side of the fill handshake
`timescale 1ns/1ps
`include "fsab_params.svh"

module ic_miss_ctrl import ic_pkg::*; import fsab_pkg::*; (
	input  logic       clk,
	input  logic       rst_b,
	input  ic_addr_t   rd_addr,
	input  logic       rd_req,
	input  logic       hit,          // From the tag store
	output logic       rd_wait,
	output logic       fsabo_valid,  // One-cycle read request
	output fsab_addr_t fsabo_addr,
	input  logic       fsabo_credit, // One credit back per pulse
	output logic       line_clear,
	output logic       line_fill,
	output ic_addr_t   fill_addr,    // Frozen while FILLING
	output logic       cur_read,     // Flips at each fill start
	input  logic       done_read     // Bus domain, copy of cur_read when done
);

	fill_state_t  state;
	fsab_credit_t credits;
	logic         credit_free;
	logic         start_fill;
	logic         done_s1;           // Sync stage one
	logic         done_sync;         // Sync stage two
	logic         fill_done;

	assign credit_free = (credits != '0);
	assign start_fill  = rd_req && !hit && (state == IDLE) && credit_free;

	// Core waits on any miss, in or out of a fill
	assign rd_wait = rd_req && !hit;

	assign fsabo_valid = start_fill;
	assign fsabo_addr  = {rd_addr[31:IC_INDEX_LSB], 6'b0}; // Line aligned

	// Completion: handshake toggles match again
	assign fill_done = (state == FILLING) && (done_sync == cur_read);
	assign line_fill = fill_done;

	// Request takes a credit, a credit pulse gives one back
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			credits <= `FSAB_INITIAL_CREDITS;
		end else begin
			credits <= credits + fsab_credit_t'(fsabo_credit) - fsab_credit_t'(fsabo_valid);
		end
	end

	// Bring the completion toggle into the core clock
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			done_s1   <= 1'b0;
			done_sync <= 1'b0;
		end else begin
			done_s1   <= done_read;
			done_sync <= done_s1;
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			state      <= IDLE;
			cur_read   <= 1'b0;
			line_clear <= 1'b0;
			fill_addr  <= '0;
		end else begin
			line_clear <= start_fill;                // Next cycle, fill_addr already latched
			case (state)
				IDLE: begin
					if (start_fill) begin
						state     <= FILLING;
						cur_read  <= ~cur_read;          // Tells the bus side a fill started
						fill_addr <= {rd_addr[31:IC_INDEX_LSB], 6'b0};
					end
				end
				FILLING: begin
					if (fill_done) begin
						state <= IDLE;                   // Line installed this edge
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* hw/ic_pkg.sv */
// Instruction cache geometry types: line tag, line index, beat position, core word, miss FSM
package ic_pkg;

	// Byte address layout: [31:10] tag, [9:6] index, [5:3] beat, [2] half, [1:0] byte
	typedef logic [31:0] ic_addr_t;   // Core byte address
	typedef logic [21:0] ic_tag_t;    // Upper bits naming a line
	typedef logic [3:0]  ic_index_t;  // One of 16 lines
	typedef logic [2:0]  ic_beat_t;   // 64-bit beat within a line
	typedef logic [31:0] ic_word_t;   // Instruction word to the core

	// Miss FSM, one fill in flight at most
	typedef enum logic {
		IDLE,                         // No fill outstanding
		FILLING                       // Waiting for the line to come back
	} fill_state_t;

	localparam int IC_TAG_LSB   = 10; // Tag field position
	localparam int IC_INDEX_LSB = 6;  // Index field position
	localparam int IC_BEAT_LSB  = 3;  // Beat field position
	localparam int IC_HALF_BIT  = 2;  // Picks high or low word of a beat

endpackage

/* hw/ic_tag_store.sv */
// Tag store with per-line valid bits and tags, hit compare, line invalidate and install
`timescale 1ns/1ps

module ic_tag_store import ic_pkg::*; (
	input  logic     clk,
	input  logic     rst_b,
	input  ic_addr_t rd_addr,    // Lookup address from the core
	input  logic     line_clear, // Drop the line at the fill index
	input  logic     line_fill,  // Install the line at the fill index
	input  ic_addr_t fill_addr,  // Line being filled
	output logic     hit
);

	logic [15:0] line_valid;     // One bit per line
	ic_tag_t     line_tag [16];  // Tag of each line

	ic_index_t rd_index;
	ic_tag_t   rd_tag;
	ic_index_t fill_index;

	assign rd_index   = rd_addr[IC_INDEX_LSB +: 4];
	assign rd_tag     = rd_addr[IC_TAG_LSB +: 22];
	assign fill_index = fill_addr[IC_INDEX_LSB +: 4];

	// Hit only on a valid entry with matching tag
	assign hit = line_valid[rd_index] && (line_tag[rd_index] == rd_tag);

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			line_valid <= '0;                 // Everything misses after reset
		end else if (line_clear) begin
			line_valid[fill_index] <= 1'b0;   // Old contents about to be overwritten
		end else if (line_fill) begin
			line_valid[fill_index] <= 1'b1;   // All eight beats are in
		end
	end

	always_ff @(posedge clk) begin
		if (line_fill) begin
			line_tag[fill_index] <= fill_addr[IC_TAG_LSB +: 22];
		end
	end

endmodule

/* hw/icache_top.sv */
// Instruction cache top level: tag store, miss control, fill unit and data array
`timescale 1ns/1ps

module icache_top import ic_pkg::*; import fsab_pkg::*; (
	input  logic         clk,
	input  logic         rst_b,
	// Core side
	input  ic_addr_t     rd_addr,
	input  logic         rd_req,
	output logic         rd_wait,
	output ic_word_t     rd_data,
	// Bus request side
	output logic         fsabo_valid,
	output fsab_addr_t   fsabo_addr,
	input  logic         fsabo_credit,
	// Bus response side, own clock
	input  logic         fsabi_clk,
	input  logic         fsabi_rst_b,
	input  logic         fsabi_valid,
	input  fsab_did_t    fsabi_did,
	input  fsab_did_t    fsabi_subdid,
	input  fsab_data_t   fsabi_data
);

	logic       hit;
	logic       line_clear;
	logic       line_fill;
	ic_addr_t   fill_addr;
	logic       cur_read;          // Core to bus toggle
	logic       done_read;         // Bus to core toggle
	logic       beat_we;
	logic [6:0] beat_index;
	fsab_data_t beat_data;

	// Lookup
	ic_tag_store u_tag_store (
		.clk        (clk),
		.rst_b      (rst_b),
		.rd_addr    (rd_addr),
		.line_clear (line_clear),
		.line_fill  (line_fill),
		.fill_addr  (fill_addr),
		.hit        (hit)
	);

	ic_miss_ctrl u_miss_ctrl (
		.clk          (clk),
		.rst_b        (rst_b),
		.rd_addr      (rd_addr),
		.rd_req       (rd_req),
		.hit          (hit),
		.rd_wait      (rd_wait),
		.fsabo_valid  (fsabo_valid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_credit (fsabo_credit),
		.line_clear   (line_clear),
		.line_fill    (line_fill),
		.fill_addr    (fill_addr),
		.cur_read     (cur_read),
		.done_read    (done_read)
	);

	// Runs on fsabi_clk
	ic_fill_unit u_fill_unit (
		.fsabi_clk    (fsabi_clk),
		.fsabi_rst_b  (fsabi_rst_b),
		.cur_read     (cur_read),
		.fill_addr    (fill_addr),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data),
		.beat_we      (beat_we),
		.beat_index   (beat_index),
		.beat_data    (beat_data),
		.done_read    (done_read)
	);

	ic_data_ram u_data_ram (
		.clk        (clk),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.fsabi_clk  (fsabi_clk),
		.beat_we    (beat_we),
		.beat_index (beat_index),
		.beat_data  (beat_data)
	);

endmodule

/* sim.f */
+incdir+hw
hw/ic_pkg.sv
hw/fsab_pkg.sv
hw/ic_tag_store.sv
hw/ic_data_ram.sv
hw/ic_miss_ctrl.sv
hw/ic_fill_unit.sv
hw/icache_top.sv
bench/icache_assertions.sv
bench/icache_tb.sv
